/* exec_pkg.sv */
package exec_pkg;

    // ------------------------------
    // datapath widths
    // ------------------------------
    localparam int word_w     = 32;
    localparam int mem_addr_w = 14;    // data memory address width, sets sp_init

    typedef logic [word_w-1:0] word_t;

    // ------------------------------
    // alu operations
    // ------------------------------
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,    // shift amount is b[4:0]
        op_srl = 3'd6,
        op_slt = 3'd7     // signed compare, 1 or 0
    } alu_op_t;

    // ------------------------------
    // special register reset values
    // ------------------------------
    // physical registers 1..3 come out of reset with these
    localparam int    n_special = 3;
    localparam word_t sp_init   = word_t'(32'd4 << mem_addr_w);    // top of data memory
    localparam word_t heap_init = 32'h0000_1000;

endpackage

/* phys_regfile.sv */
`timescale 1ns/1ns

module phys_regfile import exec_pkg::*; #(
    parameter int NUM_LANES = 2,
    parameter int PREG_W    = 6
) (
    input  logic                          clk,
    input  logic                          rstn,

    input  logic [2*NUM_LANES*PREG_W-1:0] read_addr,
    output logic [2*NUM_LANES*word_w-1:0] read_data,

    input  logic [NUM_LANES-1:0]          write_en,
    input  logic [NUM_LANES*PREG_W-1:0]   write_addr,
    input  logic [NUM_LANES*word_w-1:0]   write_data
);

    localparam int num_read = 2 * NUM_LANES;
    localparam int num_regs = 2 ** PREG_W;

    // reset values of registers 1..n_special, in order
    localparam word_t special_init [n_special] = '{word_t'(0), sp_init, heap_init};

    word_t regs [1:num_regs-1];    // register 0 has no storage

    function automatic word_t reset_value(input int r);
        if (r >= 1 && r <= n_special) begin
            return special_init[r-1];
        end
        return '0;
    endfunction

    // ------------------------------
    // read ports
    // ------------------------------
    for (genvar p = 0; p < num_read; p++) begin : g_read
        logic [PREG_W-1:0] addr;

        assign addr = read_addr[p*PREG_W +: PREG_W];
        assign read_data[p*word_w +: word_w] = (addr != '0) ? regs[addr] : '0;
    end

    // ------------------------------
    // write ports
    // ------------------------------
    for (genvar r = 1; r < num_regs; r++) begin : g_reg
        localparam word_t init_val = reset_value(r);

        logic  hit;    // any port addresses this register
        word_t hit_data;

        // later ports override earlier ones, so the highest lane wins
        always_comb begin
            hit      = 1'b0;
            hit_data = '0;
            for (int p = 0; p < NUM_LANES; p++) begin
                if (write_en[p] && write_addr[p*PREG_W +: PREG_W] == PREG_W'(r)) begin
                    hit      = 1'b1;
                    hit_data = write_data[p*word_w +: word_w];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (!rstn) begin
                regs[r] <= init_val;
            end else if (hit) begin
                regs[r] <= hit_data;
            end
        end
    end

endmodule

/* operand_forward.sv */
`timescale 1ns/1ns

module operand_forward import exec_pkg::*; #(
    parameter int NUM_LANES = 2,
    parameter int PREG_W    = 6
) (
    input  logic [2*NUM_LANES*PREG_W-1:0] src_addr,
    input  logic [2*NUM_LANES*word_w-1:0] file_data,

    input  logic [NUM_LANES-1:0]          wb_valid,
    input  logic [NUM_LANES*PREG_W-1:0]   wb_dst,
    input  logic [NUM_LANES*word_w-1:0]   wb_data,

    output logic [2*NUM_LANES*word_w-1:0] operand
);

    localparam int num_read = 2 * NUM_LANES;

    // ------------------------------
    // bypass per read port
    // ------------------------------
    // the file write lands one edge after wb, so the value in flight on the
    // wb bus is newer than what the file returns
    for (genvar p = 0; p < num_read; p++) begin : g_port
        logic [PREG_W-1:0] src;
        word_t             value;

        assign src = src_addr[p*PREG_W +: PREG_W];

        always_comb begin
            value = file_data[p*word_w +: word_w];
            for (int l = 0; l < NUM_LANES; l++) begin
                // zero source never matches, higher lane overrides
                if (wb_valid[l] && src != '0 && wb_dst[l*PREG_W +: PREG_W] == src) begin
                    value = wb_data[l*word_w +: word_w];
                end
            end
        end

        assign operand[p*word_w +: word_w] = value;
    end

endmodule

/* alu_lane.sv */
`timescale 1ns/1ns

module alu_lane import exec_pkg::*; #(
    parameter int PREG_W = 6
) (
    input  logic              clk,
    input  logic              rstn,

    input  logic              issue_valid,
    input  alu_op_t           issue_op,
    input  logic [PREG_W-1:0] issue_dst,
    input  word_t             issue_imm,
    input  logic              issue_use_imm,

    input  word_t             opa,
    input  word_t             opb,

    output logic              wb_valid,
    output logic [PREG_W-1:0] wb_dst,
    output word_t             wb_data
);

    localparam int sh_w = $clog2(word_w);

    word_t           b;
    logic [sh_w-1:0] shamt;
    word_t           result;

    assign b     = issue_use_imm ? issue_imm : opb;
    assign shamt = b[sh_w-1:0];

    // ------------------------------
    // compute
    // ------------------------------
    always_comb begin
        case (issue_op)
            op_add:  result = opa + b;
            op_sub:  result = opa - b;
            op_and:  result = opa & b;
            op_or:   result = opa | b;
            op_xor:  result = opa ^ b;
            op_sll:  result = opa << shamt;
            op_srl:  result = opa >> shamt;
            op_slt:  result = word_t'($signed(opa) < $signed(b));
            default: result = '0;
        endcase
    end

    // ------------------------------
    // write-back stage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue_valid;
        end
    end

    // payload only moves with a valid issue
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            wb_dst  <= issue_dst;
            wb_data <= result;
        end
    end

endmodule

/* exec_slice.sv */
`timescale 1ns/1ns

module exec_slice import exec_pkg::*; #(
    parameter int NUM_LANES = 2,
    parameter int PREG_W    = 6
) (
    input  logic                          clk,
    input  logic                          rstn,

    // issue, lane k in slice k
    input  logic [NUM_LANES-1:0]          issue_valid,
    input  alu_op_t [NUM_LANES-1:0]       issue_op,
    input  logic [NUM_LANES*PREG_W-1:0]   issue_src1,
    input  logic [NUM_LANES*PREG_W-1:0]   issue_src2,
    input  logic [NUM_LANES*PREG_W-1:0]   issue_dst,
    input  logic [NUM_LANES*word_w-1:0]   issue_imm,
    input  logic [NUM_LANES-1:0]          issue_use_imm,

    // write-back
    output logic [NUM_LANES-1:0]          wb_valid,
    output logic [NUM_LANES*PREG_W-1:0]   wb_dst,
    output logic [NUM_LANES*word_w-1:0]   wb_data
);

    logic [2*NUM_LANES*PREG_W-1:0] read_addr;
    logic [2*NUM_LANES*word_w-1:0] read_data;
    logic [2*NUM_LANES*word_w-1:0] operand;

    phys_regfile #(
        .NUM_LANES (NUM_LANES),
        .PREG_W    (PREG_W)
    ) i_regfile (
        .clk        (clk),
        .rstn       (rstn),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .write_en   (wb_valid),
        .write_addr (wb_dst),
        .write_data (wb_data)
    );

    operand_forward #(
        .NUM_LANES (NUM_LANES),
        .PREG_W    (PREG_W)
    ) i_forward (
        .src_addr  (read_addr),
        .file_data (read_data),
        .wb_valid  (wb_valid),
        .wb_dst    (wb_dst),
        .wb_data   (wb_data),
        .operand   (operand)
    );

    // ------------------------------
    // lanes
    // ------------------------------
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        // port 2k is src1, port 2k+1 is src2
        assign read_addr[(2*k)*PREG_W +: PREG_W]   = issue_src1[k*PREG_W +: PREG_W];
        assign read_addr[(2*k+1)*PREG_W +: PREG_W] = issue_src2[k*PREG_W +: PREG_W];

        alu_lane #(
            .PREG_W (PREG_W)
        ) i_alu (
            .clk           (clk),
            .rstn          (rstn),
            .issue_valid   (issue_valid[k]),
            .issue_op      (issue_op[k]),
            .issue_dst     (issue_dst[k*PREG_W +: PREG_W]),
            .issue_imm     (issue_imm[k*word_w +: word_w]),
            .issue_use_imm (issue_use_imm[k]),
            .opa           (operand[(2*k)*word_w +: word_w]),
            .opb           (operand[(2*k+1)*word_w +: word_w]),
            .wb_valid      (wb_valid[k]),
            .wb_dst        (wb_dst[k*PREG_W +: PREG_W]),
            .wb_data       (wb_data[k*word_w +: word_w])
        );
    end

endmodule

/* exec_slice_checker.sv */
`timescale 1ns/1ns

module exec_slice_checker import exec_pkg::*; #(
    parameter int NUM_LANES = 2,
    parameter int PREG_W    = 6
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [8*16-1:0]             test_name,

    input  logic [NUM_LANES-1:0]        issue_valid,
    input  alu_op_t [NUM_LANES-1:0]     issue_op,
    input  logic [NUM_LANES*PREG_W-1:0] issue_src1,
    input  logic [NUM_LANES*PREG_W-1:0] issue_src2,
    input  logic [NUM_LANES*PREG_W-1:0] issue_dst,
    input  logic [NUM_LANES*word_w-1:0] issue_imm,
    input  logic [NUM_LANES-1:0]        issue_use_imm,

    input  logic                        has_exp,     // table carries its own results
    input  logic [NUM_LANES*word_w-1:0] exp_data,

    input  logic [NUM_LANES-1:0]        wb_valid,
    input  logic [NUM_LANES*PREG_W-1:0] wb_dst,
    input  logic [NUM_LANES*word_w-1:0] wb_data,

    output int                          tests_done,
    output int                          tests_failed,
    output int                          other_errors
);

    localparam int num_regs = 2 ** PREG_W;

    word_t                model [num_regs];
    logic                 live;
    logic [8*16-1:0]      pend_name;
    logic [NUM_LANES-1:0] pend_valid;
    logic                 pend_has_exp;
    logic [PREG_W-1:0]    pend_dst [NUM_LANES];
    word_t                pend_data [NUM_LANES];
    word_t                pend_exp [NUM_LANES];
    int                   n_done = 0;
    int                   n_failed = 0;
    int                   n_other = 0;

    assign tests_done   = n_done;
    assign tests_failed = n_failed;
    assign other_errors = n_other;

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            op_add: return a + b;
            op_sub: return a - b;
            op_and: return a & b;
            op_or:  return a | b;
            op_xor: return a ^ b;
            op_sll: return a << b[4:0];
            op_srl: return a >> b[4:0];
            op_slt: begin
                // differing signs decide alone, otherwise unsigned order holds
                if (a[word_w-1] != b[word_w-1]) begin
                    return word_t'(a[word_w-1]);
                end
                return word_t'(a < b);
            end
            default: return '0;
        endcase
    endfunction

    function automatic word_t read_model(input logic [PREG_W-1:0] r);
        if (r == '0) begin
            return '0;
        end
        return model[r];
    endfunction

    task automatic reset_model();
        for (int r = 0; r < num_regs; r++) begin
            model[r] = '0;
        end
        model[2] = sp_init;
        model[3] = heap_init;
    endtask

    // ------------------------------
    // predict at issue
    // ------------------------------
    always @(posedge clk) begin
        word_t a;
        word_t b;

        if (!rstn) begin
            reset_model();
            live       = 1'b0;
            pend_valid = '0;
        end else begin
            live         = 1'b1;
            pend_name    = test_name;
            pend_valid   = issue_valid;
            pend_has_exp = has_exp;
            // all lanes read before any lane writes
            for (int k = 0; k < NUM_LANES; k++) begin
                if (issue_valid[k]) begin
                    a = read_model(issue_src1[k*PREG_W +: PREG_W]);
                    b = issue_use_imm[k] ? issue_imm[k*word_w +: word_w]
                                         : read_model(issue_src2[k*PREG_W +: PREG_W]);
                    pend_data[k] = alu_ref(issue_op[k], a, b);
                    pend_dst[k]  = issue_dst[k*PREG_W +: PREG_W];
                    pend_exp[k]  = exp_data[k*word_w +: word_w];
                end
            end
            for (int k = 0; k < NUM_LANES; k++) begin    // higher lane last, so it wins
                if (issue_valid[k] && pend_dst[k] != '0) begin
                    model[pend_dst[k]] = pend_data[k];
                end
            end
        end
    end

    // ------------------------------
    // compare one cycle later
    // ------------------------------
    always @(negedge clk) begin
        logic  bad;
        word_t got;

        if (live) begin
            bad = 1'b0;
            for (int k = 0; k < NUM_LANES; k++) begin
                got = wb_data[k*word_w +: word_w];
                if (pend_valid[k]) begin
                    if (wb_valid[k] !== 1'b1) begin
                        $display("no write-back from lane %0d for test %0s", k, pend_name);
                        bad = 1'b1;
                    end else if (got !== pend_data[k]) begin
                        $display("FAILED %0s lane %0d: expected %h, actual %h",
                                 pend_name, k, pend_data[k], got);
                        bad = 1'b1;
                    end else if (pend_has_exp && got !== pend_exp[k]) begin
                        $display("FAILED %0s lane %0d: expected %h, actual %h",
                                 pend_name, k, pend_exp[k], got);
                        bad = 1'b1;
                    end else if (wb_dst[k*PREG_W +: PREG_W] !== pend_dst[k]) begin
                        $display("FAILED %0s lane %0d dst: expected %0d, actual %0d",
                                 pend_name, k, pend_dst[k], wb_dst[k*PREG_W +: PREG_W]);
                        bad = 1'b1;
                    end
                end else if (wb_valid[k] === 1'b1) begin
                    $display("write-back on lane %0d without an issued instruction", k);
                    n_other++;
                end
            end
            if (pend_valid != '0) begin
                n_done++;
                if (bad) begin
                    n_failed++;
                end else begin
                    $display("passed %0s", pend_name);
                end
            end
        end
    end

endmodule

/* exec_slice_tb.sv */
`timescale 1ns/1ns

module exec_slice_tb import exec_pkg::*; ();

    localparam int NUM_LANES = 2;
    localparam int PREG_W    = 6;
    localparam int num_rows  = 40;
    localparam int timeout   = 50;    // cycles

    typedef struct packed {
        logic              valid;
        alu_op_t           op;
        logic [PREG_W-1:0] src1;
        logic [PREG_W-1:0] src2;
        logic [PREG_W-1:0] dst;
        word_t             imm;
        logic              use_imm;
    } instr_t;

    localparam instr_t nop = '0;

    logic                          clk = 1'b0;
    logic                          rstn;
    logic [NUM_LANES-1:0]          issue_valid;
    alu_op_t [NUM_LANES-1:0]       issue_op;
    logic [NUM_LANES*PREG_W-1:0]   issue_src1;
    logic [NUM_LANES*PREG_W-1:0]   issue_src2;
    logic [NUM_LANES*PREG_W-1:0]   issue_dst;
    logic [NUM_LANES*word_w-1:0]   issue_imm;
    logic [NUM_LANES-1:0]          issue_use_imm;
    logic [NUM_LANES-1:0]          wb_valid;
    logic [NUM_LANES*PREG_W-1:0]   wb_dst;
    logic [NUM_LANES*word_w-1:0]   wb_data;
    logic [8*16-1:0]               test_name;
    logic                          row_has_exp;
    logic [NUM_LANES*word_w-1:0]   row_exp;
    int                            tests_done;
    int                            tests_failed;
    int                            other_errors;

    // ------------------------------
    // stimulus table
    // ------------------------------
    instr_t          lane0_tab [num_rows];
    instr_t          lane1_tab [num_rows];
    word_t           exp0_tab [num_rows];
    word_t           exp1_tab [num_rows];
    logic            has_exp_tab [num_rows];
    logic [8*16-1:0] name_tab [num_rows];
    int              n_rows = 0;
    logic [31:0]     xs_state;

    always #20 clk = ~clk;

    exec_slice #(
        .NUM_LANES (NUM_LANES),
        .PREG_W    (PREG_W)
    ) i_exec_slice (
        .clk (clk), .rstn (rstn),
        .issue_valid (issue_valid), .issue_op (issue_op),
        .issue_src1 (issue_src1), .issue_src2 (issue_src2), .issue_dst (issue_dst),
        .issue_imm (issue_imm), .issue_use_imm (issue_use_imm),
        .wb_valid (wb_valid), .wb_dst (wb_dst), .wb_data (wb_data)
    );

    exec_slice_checker #(
        .NUM_LANES (NUM_LANES),
        .PREG_W    (PREG_W)
    ) i_checker (
        .clk (clk), .rstn (rstn), .test_name (test_name),
        .issue_valid (issue_valid), .issue_op (issue_op),
        .issue_src1 (issue_src1), .issue_src2 (issue_src2), .issue_dst (issue_dst),
        .issue_imm (issue_imm), .issue_use_imm (issue_use_imm),
        .has_exp (row_has_exp), .exp_data (row_exp),
        .wb_valid (wb_valid), .wb_dst (wb_dst), .wb_data (wb_data),
        .tests_done (tests_done), .tests_failed (tests_failed), .other_errors (other_errors)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic instr_t ri(input alu_op_t op, input logic [PREG_W-1:0] dst,
                                  input logic [PREG_W-1:0] src1, input word_t imm);
        instr_t ins;

        ins         = '0;
        ins.valid   = 1'b1;
        ins.op      = op;
        ins.dst     = dst;
        ins.src1    = src1;
        ins.imm     = imm;
        ins.use_imm = 1'b1;
        return ins;
    endfunction

    function automatic instr_t rr(input alu_op_t op, input logic [PREG_W-1:0] dst,
                                  input logic [PREG_W-1:0] src1, input logic [PREG_W-1:0] src2);
        instr_t ins;

        ins       = ri(op, dst, src1, '0);
        ins.src2  = src2;
        ins.use_imm = 1'b0;
        return ins;
    endfunction

    task automatic rand_instr(output instr_t ins);
        logic [31:0] r;

        xs_state    = xorshift(xs_state);
        r           = xs_state;
        ins.valid   = 1'b1;
        ins.op      = alu_op_t'(r[2:0]);
        ins.src1    = {2'b00, r[7:4]};    // 16 registers keeps dependencies frequent
        ins.src2    = {2'b00, r[11:8]};
        ins.dst     = {2'b00, r[15:12]};
        ins.use_imm = r[16];
        xs_state    = xorshift(xs_state);
        ins.imm     = xs_state;
    endtask

    task automatic put_row(input logic [8*16-1:0] name, input instr_t a, input word_t ea,
                           input instr_t b, input word_t eb, input logic has);
        name_tab[n_rows]    = name;
        lane0_tab[n_rows]   = a;
        lane1_tab[n_rows]   = b;
        exp0_tab[n_rows]    = ea;
        exp1_tab[n_rows]    = eb;
        has_exp_tab[n_rows] = has;
        n_rows++;
    endtask

    task automatic build_table();
        instr_t a;
        instr_t b;

        put_row("reset_vals_a", ri(op_add, 10, 1, 0), 'h0, ri(op_add, 11, 2, 0), sp_init, 1);
        put_row("reset_vals_b", ri(op_add, 12, 3, 0), heap_init, ri(op_add, 13, 0, 0), 'h0, 1);
        put_row("op_add_sub", ri(op_add, 20, 3, 'h5), 'h1005, ri(op_sub, 21, 2, 'h10), 'hfff0, 1);
        put_row("op_and_or", ri(op_and, 22, 3, 'hff00), 'h1000, rr(op_or, 23, 2, 3), 'h11000, 1);
        put_row("op_xor_sll", ri(op_xor, 24, 3, 'hffff_ffff), 'hffff_efff,
                ri(op_sll, 25, 3, 'h24), 'h10000, 1);
        put_row("op_srl_slt", ri(op_srl, 26, 2, 'h3), 'h2000, rr(op_slt, 27, 24, 3), 'h1, 1);
        put_row("slt_false", ri(op_slt, 28, 3, 'hffff_ffff), 'h0, ri(op_srl, 29, 24, 28), 'hf, 1);
        put_row("fwd_chain_a", ri(op_add, 30, 3, 'h1), 'h1001, nop, 'h0, 1);
        put_row("fwd_chain_b", ri(op_add, 31, 30, 'h1), 'h1002, rr(op_add, 32, 30, 30), 'h2002, 1);
        put_row("file_read", ri(op_add, 33, 30, 0), 'h1001, rr(op_add, 34, 31, 32), 'h3004, 1);
        put_row("same_dst", ri(op_add, 40, 3, 'h7), 'h1007, ri(op_add, 40, 2, 'h9), 'h10009, 1);
        put_row("same_dst_fwd", ri(op_add, 41, 40, 0), 'h10009, nop, 'h0, 1);
        put_row("same_dst_file", ri(op_add, 42, 40, 0), 'h10009, nop, 'h0, 1);
        put_row("write_r0", ri(op_add, 0, 3, 'h55), 'h1055, nop, 'h0, 1);
        put_row("read_r0_fwd", ri(op_add, 43, 0, 0), 'h0, rr(op_or, 44, 0, 0), 'h0, 1);
        put_row("read_r0_file", ri(op_add, 45, 0, 0), 'h0, nop, 'h0, 1);
        put_row("idle", nop, 'h0, nop, 'h0, 1);
        while (n_rows < num_rows) begin
            rand_instr(a);
            rand_instr(b);
            put_row("random", a, 'h0, b, 'h0, 0);
        end
    endtask

    task automatic drive_row(input int i);
        issue_valid   = {lane1_tab[i].valid, lane0_tab[i].valid};
        issue_op[0]   = lane0_tab[i].op;
        issue_op[1]   = lane1_tab[i].op;
        issue_src1    = {lane1_tab[i].src1, lane0_tab[i].src1};
        issue_src2    = {lane1_tab[i].src2, lane0_tab[i].src2};
        issue_dst     = {lane1_tab[i].dst, lane0_tab[i].dst};
        issue_imm     = {lane1_tab[i].imm, lane0_tab[i].imm};
        issue_use_imm = {lane1_tab[i].use_imm, lane0_tab[i].use_imm};
        test_name     = name_tab[i];
        row_has_exp   = has_exp_tab[i];
        row_exp       = {exp1_tab[i], exp0_tab[i]};
    endtask

    task automatic drive_idle();
        issue_valid   = '0;
        issue_op[0]   = op_add;
        issue_op[1]   = op_add;
        issue_src1    = '0;
        issue_src2    = '0;
        issue_dst     = '0;
        issue_imm     = '0;
        issue_use_imm = '0;
        test_name     = "idle";
        row_has_exp   = 1'b0;
        row_exp       = '0;
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int expected_tests;
        int waited;

        rstn     = 1'b0;
        xs_state = 32'd76655;
        drive_idle();
        build_table();
        expected_tests = 0;
        for (int i = 0; i < num_rows; i++) begin
            if (lane0_tab[i].valid || lane1_tab[i].valid) begin
                expected_tests++;
            end
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < num_rows; i++) begin    // back-to-back, one row per cycle
            @(negedge clk);
            drive_row(i);
        end
        @(negedge clk);
        drive_idle();

        waited = 0;
        while (tests_done < expected_tests && waited < timeout) begin
            @(posedge clk);
            waited++;
        end

        if (tests_done < expected_tests) begin
            $display("timeout: only %0d of %0d tests saw a write-back", tests_done,
                     expected_tests);
            $display("tests failed");
        end else begin
            $display("tests: %0d, failed: %0d, other errors: %0d", tests_done, tests_failed,
                     other_errors);
            if (tests_failed == 0 && other_errors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
        end
        $finish;
    end

endmodule

/* list.f */
exec_pkg.sv
phys_regfile.sv
operand_forward.sv
alu_lane.sv
exec_slice.sv
exec_slice_checker.sv
exec_slice_tb.sv
